// ==== run.sh ====
#!/bin/sh
# build and run the frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module frontend_tb -o frontend_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/frontend_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

// ==== src.f ====
src/frontend_pkg.sv
src/fetch_pc_gen.sv
src/inst_fetch.sv
src/inst_queue.sv
src/inst_decoder.sv
src/issue_buffer.sv
src/core_frontend.sv
verif/frontend_properties.sv
verif/frontend_tb.sv

// ==== src/core_frontend.sv ====
`timescale 1ns/1ps

module core_frontend #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                              clk,
  input  logic                              rst_n,
  output frontend_pkg::imem_req_t           imem_req_o,
  input  frontend_pkg::imem_resp_t          imem_resp_i,
  input  logic                              redirect_i,
  input  frontend_pkg::word_t               redirect_pc_i,
  input  logic [1:0]                        issue_i,
  input  logic                              wait_i,
  input  logic                              int_i,
  output logic [1:0]                        inst_valid_o,
  output frontend_pkg::decoded_inst_t [1:0] inst_o
);

  import frontend_pkg::*;

  word_t               fetch_pc;
  logic [1:0]          fetch_mask;
  logic                advance;
  fetch_num_t          wr_num;
  fetch_entry_t [1:0]  wr_data;
  logic                wr_room;
  logic [1:0]          q_valid;
  fetch_entry_t [1:0]  q_data;
  fetch_num_t          rd_num;
  decoded_inst_t [1:0] dec;
  logic                idle_q;
  logic                fetch_stall;

  // idle-wait latch, an interrupt wakes the frontend
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_q <= 1'b0;
    end else if (wait_i && !int_i) begin
      idle_q <= 1'b1;
    end else if (int_i) begin
      idle_q <= 1'b0;
    end
  end

  // the wait itself also blocks, since the request strobe is registered
  assign fetch_stall = idle_q || (wait_i && !int_i);

  fetch_pc_gen u_pc_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect_i   (redirect_i),
    .redirect_pc_i(redirect_pc_i),
    .advance_i    (advance),
    .pc_o         (fetch_pc),
    .valid_mask_o (fetch_mask)
  );

  inst_fetch u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect_i),
    .stall_i     (fetch_stall),
    .pc_i        (fetch_pc),
    .valid_mask_i(fetch_mask),
    .imem_req_o  (imem_req_o),
    .imem_resp_i (imem_resp_i),
    .advance_o   (advance),
    .wr_num_o    (wr_num),
    .wr_data_o   (wr_data),
    .wr_room_i   (wr_room)
  );

  inst_queue #(.DEPTH(QUEUE_DEPTH)) u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush_i   (redirect_i),
    .wr_num_i  (wr_num),
    .wr_data_i (wr_data),
    .wr_room_o (wr_room),
    .rd_valid_o(q_valid),
    .rd_data_o (q_data),
    .rd_num_i  (rd_num)
  );

  for (genvar s = 0; s < 2; s++) begin : g_dec
    inst_decoder u_dec (
      .inst_i(q_data[s].inst),
      .pc_i  (q_data[s].pc),
      .dec_o (dec[s])
    );
  end

  issue_buffer u_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect_i),
    .issue_i     (issue_i),
    .dec_i       (dec),
    .dec_valid_i (q_valid),
    .rd_num_o    (rd_num),
    .inst_valid_o(inst_valid_o),
    .inst_o      (inst_o)
  );

endmodule

// ==== src/fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                redirect_i,
  input  frontend_pkg::word_t redirect_pc_i,
  input  logic                advance_i,
  output frontend_pkg::word_t pc_o,
  output logic [1:0]          valid_mask_o
);

  import frontend_pkg::*;

  // pair address, always 8-byte aligned
  word_t pair_pc_q;
  // set when a redirect lands on the second word of a pair
  logic  skip_first_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pair_pc_q    <= '0;
      skip_first_q <= 1'b0;
    end else if (redirect_i) begin
      pair_pc_q    <= {redirect_pc_i[31:3], 3'b000};
      skip_first_q <= redirect_pc_i[2];
    end else if (advance_i) begin
      pair_pc_q    <= pair_pc_q + 32'd8;
      skip_first_q <= 1'b0;
    end
  end

  assign pc_o = pair_pc_q;

  // slot 1 is always wanted, slot 0 only without a skip
  assign valid_mask_o = {1'b1, !skip_first_q};

endmodule

// ==== src/frontend_pkg.sv ====
package frontend_pkg;

  // plain words and small counts
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  // number of instructions moved in one cycle, 0 to 2
  typedef logic [1:0]  fetch_num_t;

  // link register written by bl
  localparam reg_idx_t LINK_REG = 5'd1;

  typedef enum logic [2:0] {
    OP_ALU_RR,
    OP_ALU_RI,
    OP_STORE,
    OP_BRANCH,
    OP_BL,
    OP_INVALID
  } op_class_e;

  // register field selects used inside the decoder
  typedef enum logic [1:0] {R0_NONE, R0_RK, R0_RD} r0_sel_e;
  typedef enum logic {R1_NONE, R1_RJ} r1_sel_e;
  typedef enum logic [1:0] {W_NONE, W_RD, W_LINK} w_sel_e;

  // r_reg[0] is the first read, r_reg[1] the second
  typedef struct packed {
    reg_idx_t [1:0] r_reg;
    reg_idx_t       w_reg;
  } reg_info_t;

  // queue payload
  typedef struct packed {
    word_t pc;
    word_t inst;
  } fetch_entry_t;

  typedef struct packed {
    word_t       pc;
    word_t       inst;
    op_class_e   op_class;
    reg_info_t   reg_info;
    logic [25:0] imm;
  } decoded_inst_t;

  // instruction memory request, one-cycle strobe
  typedef struct packed {
    logic  req;
    word_t addr;
  } imem_req_t;

  // inst[0] is the word at addr, inst[1] the word at addr+4
  typedef struct packed {
    logic        valid;
    word_t [1:0] inst;
  } imem_resp_t;

endpackage

// ==== src/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
  input  frontend_pkg::word_t         inst_i,
  input  frontend_pkg::word_t         pc_i,
  output frontend_pkg::decoded_inst_t dec_o
);

  import frontend_pkg::*;

  logic [5:0] opcode;
  op_class_e  op_class;
  r0_sel_e    r0_sel;
  r1_sel_e    r1_sel;
  w_sel_e     w_sel;
  reg_info_t  reg_info;

  assign opcode = inst_i[31:26];

  // class and which fields it uses
  always_comb begin
    op_class = OP_INVALID;
    r0_sel   = R0_NONE;
    r1_sel   = R1_NONE;
    w_sel    = W_NONE;
    case (opcode[5:4])
      2'b00: begin
        op_class = OP_ALU_RR;
        r0_sel   = R0_RK;
        r1_sel   = R1_RJ;
        w_sel    = W_RD;
      end
      2'b01: begin
        op_class = OP_ALU_RI;
        r1_sel   = R1_RJ;
        w_sel    = W_RD;
      end
      2'b10: begin
        op_class = OP_STORE;
        r0_sel   = R0_RD;
        r1_sel   = R1_RJ;
      end
      default: begin
        if (opcode <= 6'h3b) begin
          op_class = OP_BRANCH;
          r0_sel   = R0_RD;
          r1_sel   = R1_RJ;
        end else if (opcode == 6'h3c) begin
          op_class = OP_BL;
          w_sel    = W_LINK;
        end
      end
    endcase
  end

  // unused indices read as r0
  always_comb begin
    case (r0_sel)
      R0_RK:   reg_info.r_reg[0] = inst_i[14:10];
      R0_RD:   reg_info.r_reg[0] = inst_i[4:0];
      default: reg_info.r_reg[0] = '0;
    endcase
    reg_info.r_reg[1] = (r1_sel == R1_RJ) ? inst_i[9:5] : '0;
    case (w_sel)
      W_RD:    reg_info.w_reg = inst_i[4:0];
      W_LINK:  reg_info.w_reg = LINK_REG;
      default: reg_info.w_reg = '0;
    endcase
  end

  assign dec_o.pc       = pc_i;
  assign dec_o.inst     = inst_i;
  assign dec_o.op_class = op_class;
  assign dec_o.reg_info = reg_info;
  // immediate field is passed for every class
  assign dec_o.imm      = inst_i[25:0];

endmodule

// ==== src/inst_fetch.sv ====
`timescale 1ns/1ps

module inst_fetch (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              flush_i,
  input  logic                              stall_i,
  input  frontend_pkg::word_t               pc_i,
  input  logic [1:0]                        valid_mask_i,
  output frontend_pkg::imem_req_t           imem_req_o,
  input  frontend_pkg::imem_resp_t          imem_resp_i,
  output logic                              advance_o,
  output frontend_pkg::fetch_num_t          wr_num_o,
  output frontend_pkg::fetch_entry_t [1:0]  wr_data_o,
  input  logic                              wr_room_i
);

  import frontend_pkg::*;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT_RESP,
    FETCH_DROP_RESP
  } fetch_state_e;

  fetch_state_e state_q, state_d;
  logic         send;
  logic         req_strobe_q;
  word_t        req_addr_q;
  logic [1:0]   mask_q;
  fetch_num_t   pair_num;

  always_comb begin
    state_d   = state_q;
    send      = 1'b0;
    advance_o = 1'b0;
    wr_num_o  = '0;
    case (state_q)
      FETCH_IDLE: begin
        if (!flush_i && !stall_i && wr_room_i) begin
          send    = 1'b1;
          state_d = FETCH_WAIT_RESP;
        end
      end
      FETCH_WAIT_RESP: begin
        if (imem_resp_i.valid) begin
          state_d = FETCH_IDLE;
          // a reply that meets a flush belongs to the old path
          if (!flush_i) begin
            advance_o = 1'b1;
            wr_num_o  = pair_num;
          end
        end else if (flush_i) begin
          state_d = FETCH_DROP_RESP;
        end
      end
      FETCH_DROP_RESP: begin
        if (imem_resp_i.valid) begin
          state_d = FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= FETCH_IDLE;
      req_strobe_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      req_strobe_q <= send;
    end
  end

  // address and mask of the pair in flight
  always_ff @(posedge clk) begin
    if (send) begin
      req_addr_q <= pc_i;
      mask_q     <= valid_mask_i;
    end
  end

  assign imem_req_o.req  = req_strobe_q;
  assign imem_req_o.addr = req_addr_q;

  assign pair_num = {1'b0, mask_q[0]} + {1'b0, mask_q[1]};

  // slot 1 moves down when slot 0 is masked off
  assign wr_data_o[0].pc   = {req_addr_q[31:3], !mask_q[0], 2'b00};
  assign wr_data_o[0].inst = mask_q[0] ? imem_resp_i.inst[0] : imem_resp_i.inst[1];
  assign wr_data_o[1].pc   = {req_addr_q[31:3], 3'b100};
  assign wr_data_o[1].inst = imem_resp_i.inst[1];

endmodule

// ==== src/inst_queue.sv ====
`timescale 1ns/1ps

module inst_queue #(
  parameter int DEPTH = 8
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              flush_i,
  input  frontend_pkg::fetch_num_t          wr_num_i,
  input  frontend_pkg::fetch_entry_t [1:0]  wr_data_i,
  output logic                              wr_room_o,
  output logic [1:0]                        rd_valid_o,
  output frontend_pkg::fetch_entry_t [1:0]  rd_data_o,
  input  frontend_pkg::fetch_num_t          rd_num_i
);

  import frontend_pkg::*;

  // pointers wrap on their own, so DEPTH is a power of two, at least 4
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  fetch_entry_t mem [DEPTH];
  ptr_t         wr_ptr_q;
  ptr_t         rd_ptr_q;
  cnt_t         cnt_q;
  ptr_t         wr_ptr_nxt;
  ptr_t         rd_ptr_nxt;

  assign wr_ptr_nxt = wr_ptr_q + ptr_t'(1);
  assign rd_ptr_nxt = rd_ptr_q + ptr_t'(1);

  // payload storage
  always_ff @(posedge clk) begin
    if (wr_num_i != '0) begin
      mem[wr_ptr_q] <= wr_data_i[0];
    end
    if (wr_num_i == 2'd2) begin
      mem[wr_ptr_nxt] <= wr_data_i[1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + ptr_t'(wr_num_i);
      rd_ptr_q <= rd_ptr_q + ptr_t'(rd_num_i);
      cnt_q    <= cnt_q + cnt_t'(wr_num_i) - cnt_t'(rd_num_i);
    end
  end

  // room for a whole pair
  assign wr_room_o = cnt_q <= cnt_t'(DEPTH - 2);

  // oldest two entries, shown before they are taken
  assign rd_valid_o   = {cnt_q >= cnt_t'(2), cnt_q != '0};
  assign rd_data_o[0] = mem[rd_ptr_q];
  assign rd_data_o[1] = mem[rd_ptr_nxt];

endmodule

// ==== src/issue_buffer.sv ====
`timescale 1ns/1ps

module issue_buffer (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               flush_i,
  input  logic [1:0]                         issue_i,
  input  frontend_pkg::decoded_inst_t [1:0]  dec_i,
  input  logic [1:0]                         dec_valid_i,
  output frontend_pkg::fetch_num_t           rd_num_o,
  output logic [1:0]                         inst_valid_o,
  output frontend_pkg::decoded_inst_t [1:0]  inst_o
);

  import frontend_pkg::*;

  logic [1:0]         valid_q;
  logic [1:0]         valid_d;
  decoded_inst_t [1:0] inst_q;
  decoded_inst_t [1:0] inst_d;
  fetch_num_t         keep_num;

  always_comb begin
    keep_num = '0;
    inst_d   = inst_q;
    valid_d  = valid_q;
    rd_num_o = '0;
    // what the backend leaves behind, oldest in slot 0
    case (valid_q)
      2'b01: begin
        if (!issue_i[0]) begin
          keep_num = 2'd1;
        end
      end
      2'b11: begin
        if (!issue_i[0]) begin
          keep_num = 2'd2;
        end else if (!issue_i[1]) begin
          keep_num  = 2'd1;
          inst_d[0] = inst_q[1];
        end
      end
      default: keep_num = '0;
    endcase
    // refill the free slots from the queue in order
    case (keep_num)
      2'd0: begin
        inst_d   = dec_i;
        valid_d  = dec_valid_i;
        rd_num_o = {1'b0, dec_valid_i[0]} + {1'b0, dec_valid_i[1]};
      end
      2'd1: begin
        inst_d[1] = dec_i[0];
        valid_d   = {dec_valid_i[0], 1'b1};
        rd_num_o  = {1'b0, dec_valid_i[0]};
      end
      default: valid_d = 2'b11;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk) begin
    inst_q <= inst_d;
  end

  assign inst_valid_o = valid_q;
  assign inst_o       = inst_q;

endmodule

// ==== verif/frontend_properties.sv ====
`timescale 1ns/1ps

module frontend_properties (
  input logic                    clk,
  input logic                    rst_n,
  input frontend_pkg::imem_req_t imem_req_i,
  input logic                    redirect_i,
  input logic [1:0]              inst_valid_i
);

  // one strobe per request, never stretched
  req_single_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    imem_req_i.req |=> !imem_req_i.req
  ) else $error("request strobe high on two consecutive cycles");

  // slot 1 is only valid behind slot 0
  valid_compact: assert property (
    @(posedge clk) disable iff (!rst_n)
    inst_valid_i != 2'b10
  ) else $error("inst_valid_o shows slot 1 without slot 0");

  redirect_clears_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    redirect_i |=> inst_valid_i == 2'b00
  ) else $error("inst_valid_o not cleared the cycle after a redirect");

endmodule

bind core_frontend frontend_properties u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .imem_req_i  (imem_req_o),
  .redirect_i  (redirect_i),
  .inst_valid_i(inst_valid_o)
);

// ==== verif/frontend_tb.sv ====
`timescale 1ns/1ps

module frontend_tb;

  import frontend_pkg::*;

  localparam logic [25:0] XOR_KEY = 26'h2c3_5a96;
  localparam int TARGET_ISSUED = 800;
  localparam int MAX_CYCLES    = 40000;
  localparam int WAIT_LIMIT    = 200;

  logic                clk = 1'b0;
  logic                rst_n;
  imem_req_t           imem_req;
  imem_resp_t          imem_resp;
  logic                redirect;
  word_t               redirect_pc;
  logic [1:0]          issue;
  logic                wait_req;
  logic                int_req;
  logic [1:0]          inst_valid;
  decoded_inst_t [1:0] inst_out;

  integer seed;
  int     err_cnt;
  int     timeout_cnt;
  int     issued_cnt;
  int     gap_left;
  word_t  exp_pc;
  logic   redirect_prev;

  // memory responder state
  logic   pending;
  int     delay_cnt;
  word_t  pend_addr;

  core_frontend #(.QUEUE_DEPTH(8)) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_req_o   (imem_req),
    .imem_resp_i  (imem_resp),
    .redirect_i   (redirect),
    .redirect_pc_i(redirect_pc),
    .issue_i      (issue),
    .wait_i       (wait_req),
    .int_i        (int_req),
    .inst_valid_o (inst_valid),
    .inst_o       (inst_out)
  );

  always #20 clk = ~clk;

  // opcode walks with the word address and the rest is a scrambled address
  function automatic word_t mem_word(input word_t a);
    word_t op;
    op = (a / 4) % 64;
    return {op[5:0], a[25:0] ^ XOR_KEY};
  endfunction

  function automatic decoded_inst_t expect_decode(input word_t pc, input word_t w);
    decoded_inst_t d;
    logic [5:0]    op;
    op         = w[31:26];
    d.pc       = pc;
    d.inst     = w;
    d.imm      = w[25:0];
    d.op_class = OP_INVALID;
    d.reg_info = '0;
    if (op <= 6'h0f) begin
      d.op_class          = OP_ALU_RR;
      d.reg_info.r_reg[0] = w[14:10];
      d.reg_info.r_reg[1] = w[9:5];
      d.reg_info.w_reg    = w[4:0];
    end else if (op <= 6'h1f) begin
      d.op_class          = OP_ALU_RI;
      d.reg_info.r_reg[1] = w[9:5];
      d.reg_info.w_reg    = w[4:0];
    end else if (op <= 6'h3b) begin
      // stores and branches read the same two fields
      d.op_class          = (op <= 6'h2f) ? OP_STORE : OP_BRANCH;
      d.reg_info.r_reg[0] = w[4:0];
      d.reg_info.r_reg[1] = w[9:5];
    end else if (op == 6'h3c) begin
      d.op_class       = OP_BL;
      d.reg_info.w_reg = LINK_REG;
    end
    return d;
  endfunction

  task automatic check(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic check_issued(input int s);
    decoded_inst_t e;
    decoded_inst_t a;
    a = inst_out[s];
    e = expect_decode(exp_pc, mem_word(exp_pc));
    check("pc", e.pc, a.pc);
    check("inst", e.inst, a.inst);
    check("op_class", 32'(e.op_class), 32'(a.op_class));
    check("read_reg0", 32'(e.reg_info.r_reg[0]), 32'(a.reg_info.r_reg[0]));
    check("read_reg1", 32'(e.reg_info.r_reg[1]), 32'(a.reg_info.r_reg[1]));
    check("write_reg", 32'(e.reg_info.w_reg), 32'(a.reg_info.w_reg));
    check("imm", 32'(e.imm), 32'(a.imm));
    exp_pc = exp_pc + 32'd4;
    issued_cnt++;
  endtask

  // answers each request after 1 to 5 cycles
  task automatic serve_memory();
    imem_resp.valid = 1'b0;
    if (imem_req.req && pending) begin
      err_cnt++;
      $display("a second fetch request was sent while one was still outstanding");
    end
    if (pending) begin
      if (delay_cnt <= 1) begin
        imem_resp.valid   = 1'b1;
        imem_resp.inst[0] = mem_word(pend_addr);
        imem_resp.inst[1] = mem_word(pend_addr + 32'd4);
        pending           = 1'b0;
      end else begin
        delay_cnt--;
      end
    end
    if (imem_req.req) begin
      check("req_align", 32'd0, 32'(imem_req.addr[2:0]));
      pending   = 1'b1;
      pend_addr = imem_req.addr;
      delay_cnt = 1 + int'($unsigned($random(seed)) % 5);
    end
  endtask

  // check what the backend takes in this cycle, then drive the next inputs
  task automatic run_cycle(input logic [1:0] issue_req, input logic redir,
                           input word_t target, input logic wt, input logic intr);
    logic [1:0] take;
    @(negedge clk);
    serve_memory();
    check("valid_pattern", 32'd0, 32'(inst_valid == 2'b10));
    if (redirect_prev) begin
      check("valid_after_redirect", 32'd0, 32'(inst_valid));
    end
    take = redir ? 2'b00 : (issue_req & inst_valid);
    if (take[0]) begin
      check_issued(0);
    end
    if (take[1]) begin
      check_issued(1);
    end
    if (redir) begin
      exp_pc = target;
    end
    issue         = take;
    redirect      = redir;
    redirect_pc   = target;
    wait_req      = wt;
    int_req       = intr;
    redirect_prev = redir;
  endtask

  // random backend with occasional long stalls
  task automatic backend_issue(output logic [1:0] req);
    if (gap_left > 0) begin
      gap_left--;
      req = 2'b00;
    end else if ($unsigned($random(seed)) % 24 == 0) begin
      gap_left = 8 + int'($unsigned($random(seed)) % 40);
      req      = 2'b00;
    end else begin
      case ($unsigned($random(seed)) % 3)
        0:       req = 2'b00;
        1:       req = 2'b01;
        default: req = 2'b11;
      endcase
    end
  endtask

  task automatic idle_phase();
    logic [1:0] req;
    int         n;
    int         waited;
    backend_issue(req);
    run_cycle(req, 1'b0, '0, 1'b1, 1'b0);
    n = 4 + int'($unsigned($random(seed)) % 16);
    for (int k = 0; k < n; k++) begin
      backend_issue(req);
      run_cycle(req, 1'b0, '0, 1'b0, 1'b0);
      check("idle_req", 32'd0, 32'(imem_req.req));
    end
    backend_issue(req);
    run_cycle(req, 1'b0, '0, 1'b0, 1'b1);
    waited = 0;
    while (!imem_req.req && waited < WAIT_LIMIT) begin
      run_cycle(2'b11, 1'b0, '0, 1'b0, 1'b0);
      waited++;
    end
    if (!imem_req.req) begin
      timeout_cnt++;
      $display("timeout: no fetch request after the interrupt ended the idle wait");
    end
  endtask

  initial begin
    logic [1:0] req;
    int         waited;
    int         cycles;
    int         roll;
    word_t      target;
    seed          = 76140;
    err_cnt       = 0;
    timeout_cnt   = 0;
    issued_cnt    = 0;
    gap_left      = 0;
    exp_pc        = '0;
    redirect_prev = 1'b0;
    pending       = 1'b0;
    delay_cnt     = 0;
    pend_addr     = '0;
    rst_n         = 1'b0;
    imem_resp     = '0;
    redirect      = 1'b0;
    redirect_pc   = '0;
    issue         = 2'b00;
    wait_req      = 1'b0;
    int_req       = 1'b0;

    repeat (16) begin
      @(negedge clk);
      check("reset_valid", 32'd0, 32'(inst_valid));
      check("reset_req", 32'd0, 32'(imem_req.req));
    end
    rst_n = 1'b1;

    // first fetch goes to pair 0
    waited = 0;
    while (!imem_req.req && waited < WAIT_LIMIT) begin
      run_cycle(2'b00, 1'b0, '0, 1'b0, 1'b0);
      waited++;
    end
    if (!imem_req.req) begin
      timeout_cnt++;
      $display("timeout: no fetch request after reset");
    end else begin
      check("first_req_addr", 32'd0, imem_req.addr);
    end

    cycles = 0;
    while (issued_cnt < TARGET_ISSUED && cycles < MAX_CYCLES) begin
      roll = int'($unsigned($random(seed)) % 200);
      if (roll < 3) begin
        target = word_t'($random(seed)) & 32'h0000_0ffc;
        run_cycle(2'b00, 1'b1, target, 1'b0, 1'b0);
      end else if (roll == 3) begin
        idle_phase();
      end else begin
        backend_issue(req);
        run_cycle(req, 1'b0, '0, 1'b0, 1'b0);
      end
      cycles++;
    end
    if (issued_cnt < TARGET_ISSUED) begin
      timeout_cnt++;
      $display("timeout: only %0d instructions issued before the cycle limit", issued_cnt);
    end

    $display("summary: %0d instructions checked, %0d value errors, %0d timeouts",
             issued_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
